// ==== rtl/core_defs.svh ====
`ifndef CORE_DEFS_SVH
`define CORE_DEFS_SVH

// datapath width
`define CORE_XLEN 32

// architectural register file
`define CORE_NREGS 32
`define CORE_RIDX_W 5

// strobe to retire, decode + execute + result register
`define CORE_LATENCY 3

`endif

// ==== rtl/isa_pkg.sv ====
package isa_pkg;

    // alu function selected by decode
    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLT, ALU_SLTU,
        ALU_AND, ALU_NOR, ALU_OR, ALU_XOR,
        ALU_SLL, ALU_SRL, ALU_SRA, ALU_LUI
    } alu_op_e;

    typedef enum logic [3:0] {
        BR_NONE, BR_BEQ, BR_BNE, BR_BLT, BR_BGE,
        BR_BLTU, BR_BGEU, BR_B, BR_BL, BR_JIRL
    } br_op_e;

    typedef enum logic [2:0] {
        IMM_NONE, IMM_UI5, IMM_SI12, IMM_UI12, IMM_SI20, IMM_FOUR
    } imm_kind_e;

    // major opcode, insn[31:26]
    localparam logic [5:0] OP6_ALU       = 6'h00;
    localparam logic [5:0] OP6_LU12I     = 6'h05;
    localparam logic [5:0] OP6_PCADDU12I = 6'h07;
    localparam logic [5:0] OP6_JIRL      = 6'h13;
    localparam logic [5:0] OP6_B         = 6'h14;
    localparam logic [5:0] OP6_BL        = 6'h15;
    localparam logic [5:0] OP6_BEQ       = 6'h16;
    localparam logic [5:0] OP6_BNE       = 6'h17;
    localparam logic [5:0] OP6_BLT       = 6'h18;
    localparam logic [5:0] OP6_BGE       = 6'h19;
    localparam logic [5:0] OP6_BLTU      = 6'h1a;
    localparam logic [5:0] OP6_BGEU      = 6'h1b;

    // insn[25:22] under OP6_ALU
    localparam logic [3:0] OP4_3R     = 4'h0;
    localparam logic [3:0] OP4_SHIFTI = 4'h1;
    localparam logic [3:0] OP4_SLTI   = 4'h8;
    localparam logic [3:0] OP4_SLTUI  = 4'h9;
    localparam logic [3:0] OP4_ADDI   = 4'ha;
    localparam logic [3:0] OP4_ANDI   = 4'hd;
    localparam logic [3:0] OP4_ORI    = 4'he;
    localparam logic [3:0] OP4_XORI   = 4'hf;

    // insn[21:20]
    localparam logic [1:0] OP2_3R     = 2'h1;
    localparam logic [1:0] OP2_SHIFTI = 2'h0;

    // insn[19:15], register forms
    localparam logic [4:0] OP5_ADD  = 5'h00;
    localparam logic [4:0] OP5_SUB  = 5'h02;
    localparam logic [4:0] OP5_SLT  = 5'h04;
    localparam logic [4:0] OP5_SLTU = 5'h05;
    localparam logic [4:0] OP5_NOR  = 5'h08;
    localparam logic [4:0] OP5_AND  = 5'h09;
    localparam logic [4:0] OP5_OR   = 5'h0a;
    localparam logic [4:0] OP5_XOR  = 5'h0b;
    localparam logic [4:0] OP5_SLL  = 5'h0e;
    localparam logic [4:0] OP5_SRL  = 5'h0f;
    localparam logic [4:0] OP5_SRA  = 5'h10;
    // insn[19:15], shift by immediate
    localparam logic [4:0] OP5_SLLI = 5'h01;
    localparam logic [4:0] OP5_SRLI = 5'h09;
    localparam logic [4:0] OP5_SRAI = 5'h11;

    // field positions
    localparam int RD_LSB  = 0;
    localparam int RJ_LSB  = 5;
    localparam int RK_LSB  = 10;
    localparam int I12_LSB = 10;
    localparam int I16_LSB = 10;
    localparam int I20_LSB = 5;

endpackage

// ==== rtl/pipe_pkg.sv ====
`include "core_defs.svh"

package pipe_pkg;

    typedef logic [`CORE_XLEN-1:0] word_t;

    typedef logic [`CORE_RIDX_W-1:0] reg_idx_t;

    // one register write, 1 + 5 + 32 bits
    typedef struct packed {
        logic     we;
        reg_idx_t dest;
        word_t    value;
    } wb_t;

endpackage

// ==== rtl/stage_ifs.sv ====
`timescale 1ns/100ps

// decode to execute
interface dec_exe_if;
    logic                valid;
    pipe_pkg::word_t     pc;
    isa_pkg::alu_op_e    alu_op;
    pipe_pkg::word_t     src1;
    pipe_pkg::word_t     src2;
    pipe_pkg::word_t     cmp_a;
    pipe_pkg::word_t     cmp_b;
    isa_pkg::br_op_e     br_op;
    pipe_pkg::word_t     br_offset;
    logic                we;
    pipe_pkg::reg_idx_t  dest;
    logic                illegal;

    modport decode (output valid, pc, alu_op, src1, src2, cmp_a, cmp_b,
                    br_op, br_offset, we, dest, illegal);
    modport execute (input valid, pc, alu_op, src1, src2, cmp_a, cmp_b,
                     br_op, br_offset, we, dest, illegal);
endinterface

// execute to result, also tapped by decode for forwarding
interface exe_res_if;
    logic             valid;
    pipe_pkg::word_t  pc;
    pipe_pkg::wb_t    wb;
    logic             br_taken;
    pipe_pkg::word_t  br_target;
    logic             illegal;

    modport execute (output valid, pc, wb, br_taken, br_target, illegal);
    modport result (input valid, pc, wb, br_taken, br_target, illegal);
    modport fwd (input wb);
endinterface

// two read ports of the register file
interface rf_read_if;
    pipe_pkg::reg_idx_t raddr1;
    pipe_pkg::reg_idx_t raddr2;
    pipe_pkg::word_t    rdata1;
    pipe_pkg::word_t    rdata2;

    modport reader (output raddr1, raddr2, input rdata1, rdata2);
    modport regs (input raddr1, raddr2, output rdata1, rdata2);
endinterface

// ==== rtl/insn_decode.sv ====
`timescale 1ns/100ps

module insn_decode (
    input  logic               clk,
    input  logic               resetn,
    input  logic               insn_valid,
    input  pipe_pkg::word_t    insn,
    input  pipe_pkg::word_t    insn_pc,
    dec_exe_if.decode          dec_out,
    exe_res_if.fwd             exe_fwd,
    rf_read_if.reader          rf
);

    logic                d_valid;
    pipe_pkg::word_t     d_insn;
    pipe_pkg::word_t     d_pc;

    logic [5:0]          op6;
    logic [3:0]          op4;
    logic [1:0]          op2;
    logic [4:0]          op5;
    pipe_pkg::reg_idx_t  rd;
    pipe_pkg::reg_idx_t  rj;
    pipe_pkg::reg_idx_t  rk;
    logic [11:0]         i12;
    logic [15:0]         i16;
    logic [19:0]         i20;
    logic [25:0]         i26;

    isa_pkg::alu_op_e    alu_op;
    isa_pkg::br_op_e     br_op;
    isa_pkg::imm_kind_e  imm_kind;
    logic                legal;
    logic                gr_we;
    logic                src1_is_pc;
    logic                cond_br;
    pipe_pkg::word_t     imm;
    pipe_pkg::word_t     rj_value;
    pipe_pkg::word_t     rkd_value;
    logic                fwd1;
    logic                fwd2;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            d_valid <= 1'b0;
        end else begin
            d_valid <= insn_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (insn_valid) begin
            d_insn <= insn;
            d_pc   <= insn_pc;
        end
    end

    assign op6 = d_insn[31:26];
    assign op4 = d_insn[25:22];
    assign op2 = d_insn[21:20];
    assign op5 = d_insn[19:15];
    assign rd  = d_insn[isa_pkg::RD_LSB +: 5];
    assign rj  = d_insn[isa_pkg::RJ_LSB +: 5];
    assign rk  = d_insn[isa_pkg::RK_LSB +: 5];
    assign i12 = d_insn[isa_pkg::I12_LSB +: 12];
    assign i16 = d_insn[isa_pkg::I16_LSB +: 16];
    assign i20 = d_insn[isa_pkg::I20_LSB +: 20];
    // offs[15:0] sits above offs[25:16] in the word
    assign i26 = {d_insn[9:0], d_insn[25:10]};

    always_comb begin
        alu_op     = isa_pkg::ALU_ADD;
        br_op      = isa_pkg::BR_NONE;
        imm_kind   = isa_pkg::IMM_NONE;
        legal      = 1'b1;
        gr_we      = 1'b1;
        src1_is_pc = 1'b0;
        cond_br    = 1'b0;
        if (op6 == isa_pkg::OP6_ALU && op4 == isa_pkg::OP4_3R && op2 == isa_pkg::OP2_3R) begin
            case (op5)
                isa_pkg::OP5_ADD:  alu_op = isa_pkg::ALU_ADD;
                isa_pkg::OP5_SUB:  alu_op = isa_pkg::ALU_SUB;
                isa_pkg::OP5_SLT:  alu_op = isa_pkg::ALU_SLT;
                isa_pkg::OP5_SLTU: alu_op = isa_pkg::ALU_SLTU;
                isa_pkg::OP5_NOR:  alu_op = isa_pkg::ALU_NOR;
                isa_pkg::OP5_AND:  alu_op = isa_pkg::ALU_AND;
                isa_pkg::OP5_OR:   alu_op = isa_pkg::ALU_OR;
                isa_pkg::OP5_XOR:  alu_op = isa_pkg::ALU_XOR;
                isa_pkg::OP5_SLL:  alu_op = isa_pkg::ALU_SLL;
                isa_pkg::OP5_SRL:  alu_op = isa_pkg::ALU_SRL;
                isa_pkg::OP5_SRA:  alu_op = isa_pkg::ALU_SRA;
                default:           legal  = 1'b0;
            endcase
        end else if (op6 == isa_pkg::OP6_ALU && op4 == isa_pkg::OP4_SHIFTI
                     && op2 == isa_pkg::OP2_SHIFTI) begin
            imm_kind = isa_pkg::IMM_UI5;
            case (op5)
                isa_pkg::OP5_SLLI: alu_op = isa_pkg::ALU_SLL;
                isa_pkg::OP5_SRLI: alu_op = isa_pkg::ALU_SRL;
                isa_pkg::OP5_SRAI: alu_op = isa_pkg::ALU_SRA;
                default:           legal  = 1'b0;
            endcase
        end else if (op6 == isa_pkg::OP6_ALU) begin
            imm_kind = isa_pkg::IMM_SI12;
            case (op4)
                isa_pkg::OP4_SLTI:  alu_op = isa_pkg::ALU_SLT;
                isa_pkg::OP4_SLTUI: alu_op = isa_pkg::ALU_SLTU;
                isa_pkg::OP4_ADDI:  alu_op = isa_pkg::ALU_ADD;
                isa_pkg::OP4_ANDI: begin
                    alu_op   = isa_pkg::ALU_AND;
                    imm_kind = isa_pkg::IMM_UI12;
                end
                isa_pkg::OP4_ORI: begin
                    alu_op   = isa_pkg::ALU_OR;
                    imm_kind = isa_pkg::IMM_UI12;
                end
                isa_pkg::OP4_XORI: begin
                    alu_op   = isa_pkg::ALU_XOR;
                    imm_kind = isa_pkg::IMM_UI12;
                end
                default: legal = 1'b0;
            endcase
        end else begin
            case (op6)
                isa_pkg::OP6_LU12I: begin
                    alu_op   = isa_pkg::ALU_LUI;
                    imm_kind = isa_pkg::IMM_SI20;
                    legal    = ~d_insn[25];
                end
                isa_pkg::OP6_PCADDU12I: begin
                    imm_kind   = isa_pkg::IMM_SI20;
                    src1_is_pc = 1'b1;
                    legal      = ~d_insn[25];
                end
                isa_pkg::OP6_JIRL: begin
                    br_op      = isa_pkg::BR_JIRL;
                    imm_kind   = isa_pkg::IMM_FOUR;
                    src1_is_pc = 1'b1;
                end
                isa_pkg::OP6_BL: begin
                    br_op      = isa_pkg::BR_BL;
                    imm_kind   = isa_pkg::IMM_FOUR;
                    src1_is_pc = 1'b1;
                end
                isa_pkg::OP6_B: begin
                    br_op = isa_pkg::BR_B;
                    gr_we = 1'b0;
                end
                isa_pkg::OP6_BEQ, isa_pkg::OP6_BNE, isa_pkg::OP6_BLT,
                isa_pkg::OP6_BGE, isa_pkg::OP6_BLTU, isa_pkg::OP6_BGEU: begin
                    gr_we   = 1'b0;
                    cond_br = 1'b1;
                    case (op6)
                        isa_pkg::OP6_BEQ:  br_op = isa_pkg::BR_BEQ;
                        isa_pkg::OP6_BNE:  br_op = isa_pkg::BR_BNE;
                        isa_pkg::OP6_BLT:  br_op = isa_pkg::BR_BLT;
                        isa_pkg::OP6_BGE:  br_op = isa_pkg::BR_BGE;
                        isa_pkg::OP6_BLTU: br_op = isa_pkg::BR_BLTU;
                        default:           br_op = isa_pkg::BR_BGEU;
                    endcase
                end
                default: legal = 1'b0;
            endcase
        end
    end

    always_comb begin
        case (imm_kind)
            isa_pkg::IMM_UI5:  imm = {27'b0, rk};
            isa_pkg::IMM_SI12: imm = {{20{i12[11]}}, i12};
            isa_pkg::IMM_UI12: imm = {20'b0, i12};
            isa_pkg::IMM_SI20: imm = {i20, 12'b0};
            isa_pkg::IMM_FOUR: imm = 32'd4;
            default:           imm = '0;
        endcase
    end

    // conditional branches compare rj against rd
    assign rf.raddr1 = rj;
    assign rf.raddr2 = cond_br ? rd : rk;

    // newest value wins over the register file and its bypass
    assign fwd1 = exe_fwd.wb.we && rf.raddr1 != '0 && exe_fwd.wb.dest == rf.raddr1;
    assign fwd2 = exe_fwd.wb.we && rf.raddr2 != '0 && exe_fwd.wb.dest == rf.raddr2;
    assign rj_value  = fwd1 ? exe_fwd.wb.value : rf.rdata1;
    assign rkd_value = fwd2 ? exe_fwd.wb.value : rf.rdata2;

    assign dec_out.valid   = d_valid;
    assign dec_out.pc      = d_pc;
    assign dec_out.alu_op  = alu_op;
    assign dec_out.src1    = src1_is_pc ? d_pc : rj_value;
    assign dec_out.src2    = (imm_kind != isa_pkg::IMM_NONE) ? imm : rkd_value;
    assign dec_out.cmp_a   = rj_value;
    assign dec_out.cmp_b   = rkd_value;
    assign dec_out.br_op   = br_op;
    assign dec_out.br_offset = (br_op == isa_pkg::BR_B || br_op == isa_pkg::BR_BL)
                             ? {{4{i26[25]}}, i26, 2'b0}
                             : {{14{i16[15]}}, i16, 2'b0};
    assign dec_out.we      = gr_we & legal;
    assign dec_out.dest    = (br_op == isa_pkg::BR_BL) ? 5'd1 : rd;
    assign dec_out.illegal = ~legal;

endmodule

// ==== rtl/alu_execute.sv ====
`timescale 1ns/100ps

module alu_execute (
    input  logic          clk,
    input  logic          resetn,
    dec_exe_if.execute    dec_in,
    exe_res_if.execute    res_out
);

    logic                e_valid;
    pipe_pkg::word_t     e_pc;
    isa_pkg::alu_op_e    e_alu_op;
    pipe_pkg::word_t     e_src1;
    pipe_pkg::word_t     e_src2;
    pipe_pkg::word_t     e_cmp_a;
    pipe_pkg::word_t     e_cmp_b;
    isa_pkg::br_op_e     e_br_op;
    pipe_pkg::word_t     e_br_offset;
    logic                e_we;
    pipe_pkg::reg_idx_t  e_dest;
    logic                e_illegal;

    pipe_pkg::word_t     alu_result;
    logic                cond;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            e_valid <= 1'b0;
        end else begin
            e_valid <= dec_in.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (dec_in.valid) begin
            e_pc        <= dec_in.pc;
            e_alu_op    <= dec_in.alu_op;
            e_src1      <= dec_in.src1;
            e_src2      <= dec_in.src2;
            e_cmp_a     <= dec_in.cmp_a;
            e_cmp_b     <= dec_in.cmp_b;
            e_br_op     <= dec_in.br_op;
            e_br_offset <= dec_in.br_offset;
            e_we        <= dec_in.we;
            e_dest      <= dec_in.dest;
            e_illegal   <= dec_in.illegal;
        end
    end

    always_comb begin
        case (e_alu_op)
            isa_pkg::ALU_ADD:  alu_result = e_src1 + e_src2;
            isa_pkg::ALU_SUB:  alu_result = e_src1 - e_src2;
            isa_pkg::ALU_SLT:  alu_result = {31'b0, $signed(e_src1) < $signed(e_src2)};
            isa_pkg::ALU_SLTU: alu_result = {31'b0, e_src1 < e_src2};
            isa_pkg::ALU_AND:  alu_result = e_src1 & e_src2;
            isa_pkg::ALU_NOR:  alu_result = ~(e_src1 | e_src2);
            isa_pkg::ALU_OR:   alu_result = e_src1 | e_src2;
            isa_pkg::ALU_XOR:  alu_result = e_src1 ^ e_src2;
            isa_pkg::ALU_SLL:  alu_result = e_src1 << e_src2[4:0];
            isa_pkg::ALU_SRL:  alu_result = e_src1 >> e_src2[4:0];
            isa_pkg::ALU_SRA:  alu_result = $signed(e_src1) >>> e_src2[4:0];
            isa_pkg::ALU_LUI:  alu_result = e_src2;
            default:           alu_result = '0;
        endcase
    end

    // branch condition on the raw register operands
    always_comb begin
        case (e_br_op)
            isa_pkg::BR_BEQ:  cond = e_cmp_a == e_cmp_b;
            isa_pkg::BR_BNE:  cond = e_cmp_a != e_cmp_b;
            isa_pkg::BR_BLT:  cond = $signed(e_cmp_a) < $signed(e_cmp_b);
            isa_pkg::BR_BGE:  cond = $signed(e_cmp_a) >= $signed(e_cmp_b);
            isa_pkg::BR_BLTU: cond = e_cmp_a < e_cmp_b;
            isa_pkg::BR_BGEU: cond = e_cmp_a >= e_cmp_b;
            isa_pkg::BR_B, isa_pkg::BR_BL, isa_pkg::BR_JIRL: cond = 1'b1;
            default:          cond = 1'b0;
        endcase
    end

    assign res_out.valid     = e_valid;
    assign res_out.pc        = e_pc;
    assign res_out.wb        = '{we: e_valid & e_we, dest: e_dest, value: alu_result};
    assign res_out.br_taken  = e_valid & cond;
    assign res_out.br_target = ((e_br_op == isa_pkg::BR_JIRL) ? e_cmp_a : e_pc) + e_br_offset;
    assign res_out.illegal   = e_illegal;

endmodule

// ==== rtl/result_writeback.sv ====
`timescale 1ns/100ps
`include "core_defs.svh"

module result_writeback (
    input  logic                clk,
    input  logic                resetn,
    exe_res_if.result           res_in,
    rf_read_if.regs             rf,
    output logic                result_valid,
    output pipe_pkg::word_t     result_pc,
    output logic                result_we,
    output pipe_pkg::reg_idx_t  result_dest,
    output pipe_pkg::word_t     result_value,
    output logic                result_illegal,
    output logic                branch_taken,
    output pipe_pkg::word_t     branch_target
);

    logic                r_valid;
    logic                r_we;
    logic                r_taken;
    pipe_pkg::word_t     r_pc;
    pipe_pkg::reg_idx_t  r_dest;
    pipe_pkg::word_t     r_value;
    pipe_pkg::word_t     r_target;
    logic                r_illegal;

    pipe_pkg::word_t     regs [`CORE_NREGS];

    // r0 reads zero, the pending write passes straight through
    function automatic pipe_pkg::word_t read_port(input pipe_pkg::reg_idx_t addr);
        if (addr == '0) begin
            return '0;
        end else if (r_we && addr == r_dest) begin
            return r_value;
        end
        return regs[addr];
    endfunction

    always_ff @(posedge clk) begin
        if (!resetn) begin
            r_valid <= 1'b0;
            r_we    <= 1'b0;
            r_taken <= 1'b0;
        end else begin
            r_valid <= res_in.valid;
            r_we    <= res_in.wb.we;
            r_taken <= res_in.br_taken;
        end
    end

    always_ff @(posedge clk) begin
        r_pc      <= res_in.pc;
        r_dest    <= res_in.wb.dest;
        r_value   <= res_in.wb.value;
        r_target  <= res_in.br_target;
        r_illegal <= res_in.illegal;
    end

    always_ff @(posedge clk) begin
        if (r_we && r_dest != '0) begin
            regs[r_dest] <= r_value;
        end
    end

    // reads follow the file and the result register, not only the address
    always_comb begin
        rf.rdata1 = read_port(rf.raddr1);
        rf.rdata2 = read_port(rf.raddr2);
    end

    assign result_valid   = r_valid;
    assign result_pc      = r_pc;
    assign result_we      = r_we;
    assign result_dest    = r_dest;
    assign result_value   = r_value;
    assign result_illegal = r_illegal;
    assign branch_taken   = r_taken;
    assign branch_target  = r_target;

endmodule

// ==== rtl/core_top.sv ====
`timescale 1ns/100ps

// decode, execute and result registers in a row
// retire follows the strobe by `CORE_LATENCY cycles, in order
module core_top (
    input  logic                clk,
    input  logic                resetn,
    input  logic                insn_valid,
    input  pipe_pkg::word_t     insn,
    input  pipe_pkg::word_t     insn_pc,
    output logic                result_valid,
    output pipe_pkg::word_t     result_pc,
    output logic                result_we,
    output pipe_pkg::reg_idx_t  result_dest,
    output pipe_pkg::word_t     result_value,
    output logic                result_illegal,
    output logic                branch_taken,
    output pipe_pkg::word_t     branch_target
);

    dec_exe_if u_dec_exe ();
    exe_res_if u_exe_res ();
    rf_read_if u_rf_read ();

    insn_decode u_decode (
        .clk        (clk),
        .resetn     (resetn),
        .insn_valid (insn_valid),
        .insn       (insn),
        .insn_pc    (insn_pc),
        .dec_out    (u_dec_exe.decode),
        .exe_fwd    (u_exe_res.fwd),
        .rf         (u_rf_read.reader)
    );

    alu_execute u_execute (
        .clk     (clk),
        .resetn  (resetn),
        .dec_in  (u_dec_exe.execute),
        .res_out (u_exe_res.execute)
    );

    // branches are only reported, the front end steers fetch
    result_writeback u_result (
        .clk            (clk),
        .resetn         (resetn),
        .res_in         (u_exe_res.result),
        .rf             (u_rf_read.regs),
        .result_valid   (result_valid),
        .result_pc      (result_pc),
        .result_we      (result_we),
        .result_dest    (result_dest),
        .result_value   (result_value),
        .result_illegal (result_illegal),
        .branch_taken   (branch_taken),
        .branch_target  (branch_target)
    );

endmodule

// ==== testbench/tb_core.sv ====
`timescale 1ns/100ps
`include "core_defs.svh"

module tb_core;

    localparam int MAX_INSN = 64;
    localparam int FIELDS   = 8;

    logic                clk;
    logic                resetn;
    logic                insn_valid;
    pipe_pkg::word_t     insn;
    pipe_pkg::word_t     insn_pc;
    logic                result_valid;
    pipe_pkg::word_t     result_pc;
    logic                result_we;
    pipe_pkg::reg_idx_t  result_dest;
    pipe_pkg::word_t     result_value;
    logic                result_illegal;
    logic                branch_taken;
    pipe_pkg::word_t     branch_target;

    // word 0 is the count, then FIELDS words per instruction
    logic [31:0]         stim [0:FIELDS*MAX_INSN];
    int                  n_insn;
    int                  pend_idx [$];
    int                  pend_cycle [$];
    int                  cycle = 0;
    int                  mismatches = 0;
    int                  other_errors = 0;
    logic [31:0]         lfsr;

    core_top u_dut (
        .clk            (clk),
        .resetn         (resetn),
        .insn_valid     (insn_valid),
        .insn           (insn),
        .insn_pc        (insn_pc),
        .result_valid   (result_valid),
        .result_pc      (result_pc),
        .result_we      (result_we),
        .result_dest    (result_dest),
        .result_value   (result_value),
        .result_illegal (result_illegal),
        .branch_taken   (branch_taken),
        .branch_target  (branch_target)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("Fail at %t: %s got %h expected %h", $time, name, got, exp);
            mismatches++;
        end
    endtask

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic draw_gap(output int gap);
        gap = 0;
        repeat (2) begin
            lfsr = lfsr_next(lfsr);
            gap = (gap << 1) | int'(lfsr[0]);
        end
    endtask

    task automatic check_retire(input int idx, input int strobe_cycle);
        int base;
        base = 1 + FIELDS * idx;
        check_value("result_pc", result_pc, stim[base + 1]);
        check_value("latency", cycle - strobe_cycle, `CORE_LATENCY);
        check_value("result_we", {31'b0, result_we}, stim[base + 2]);
        // dest and value only mean something for a write
        if (stim[base + 2][0]) begin
            check_value("result_dest", {27'b0, result_dest}, stim[base + 3]);
            check_value("result_value", result_value, stim[base + 4]);
        end
        check_value("result_illegal", {31'b0, result_illegal}, stim[base + 5]);
        check_value("branch_taken", {31'b0, branch_taken}, stim[base + 6]);
        if (stim[base + 6][0]) begin
            check_value("branch_target", branch_target, stim[base + 7]);
        end
    endtask

    task automatic send_insn(input int idx);
        @(posedge clk);
        #0.5;
        insn_valid = 1'b1;
        insn       = stim[1 + FIELDS * idx];
        insn_pc    = stim[2 + FIELDS * idx];
        pend_idx.push_back(idx);
        pend_cycle.push_back(cycle);
    endtask

    task automatic run_stream(input logic with_gaps);
        int gap;
        for (int i = 0; i < n_insn; i++) begin
            send_insn(i);
            gap = 0;
            if (with_gaps) begin
                draw_gap(gap);
            end
            repeat (gap) begin
                @(posedge clk);
                #0.5;
                insn_valid = 1'b0;
            end
        end
        @(posedge clk);
        #0.5;
        insn_valid = 1'b0;
    endtask

    // retire monitor, half a cycle away from the driving edge
    always @(negedge clk) begin
        if (resetn === 1'b1) begin
            if (result_valid === 1'b1) begin
                if (pend_idx.size() == 0) begin
                    $display("Error at %t: result_valid with no instruction in flight", $time);
                    other_errors++;
                end else begin
                    check_retire(pend_idx.pop_front(), pend_cycle.pop_front());
                end
            end else if (result_valid !== 1'b0) begin
                $display("Error at %t: result_valid is unknown", $time);
                other_errors++;
            end
        end
    end

    initial begin
        int drain;
        $timeformat(-9, 1, " ns", 0);
        resetn     = 1'b0;
        insn_valid = 1'b0;
        insn       = '0;
        insn_pc    = '0;
        lfsr       = 32'hcc25;
        $readmemh("testbench/core_stim.txt", stim);
        n_insn = stim[0];
        if (n_insn < 1 || n_insn > MAX_INSN) begin
            $display("Error: stimulus file gives a bad instruction count %0d", n_insn);
            other_errors++;
            n_insn = 0;
        end

        repeat (5) @(posedge clk);
        #0.5;
        resetn = 1'b1;
        // quiet period, nothing may retire
        repeat (6) @(posedge clk);

        // same program twice, random gaps then back to back
        run_stream(1'b1);
        run_stream(1'b0);

        drain = 0;
        while (pend_idx.size() != 0 && drain < 20) begin
            @(posedge clk);
            drain++;
        end
        if (pend_idx.size() != 0) begin
            $display("Error: timeout, %0d instructions never retired", pend_idx.size());
            other_errors++;
        end

        $display("errors: %0d mismatches, %0d other failures", mismatches, other_errors);
        if (mismatches + other_errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

// ==== testbench/core_stim.txt ====
// first word: instruction count in hex
// then per line: insn pc we dest value illegal taken target
27
142468A1 1C000000 1 01 12345000 0 0 00000000
0399E021 1C000004 1 01 12345678 0 0 00000000
02BFFC02 1C000008 1 02 FFFFFFFF 0 0 00000000
02801403 1C00000C 1 03 00000005 0 0 00000000
00100C24 1C000010 1 04 1234567D 0 0 00000000
00110865 1C000014 1 05 00000006 0 0 00000000
00120C46 1C000018 1 06 00000001 0 0 00000000
00128C47 1C00001C 1 07 00000000 0 0 00000000
00140028 1C000020 1 08 EDCBA987 0 0 00000000
0014A089 1C000024 1 09 00000005 0 0 00000000
001514CA 1C000028 1 0A 00000007 0 0 00000000
0015882B 1C00002C 1 0B EDCBA987 0 0 00000000
0280900D 1C000030 1 0D 00000024 0 0 00000000
0017342C 1C000034 1 0C 23456780 0 0 00000000
0017B50E 1C000038 1 0E 0EDCBA98 0 0 00000000
0018350F 1C00003C 1 0F FEDCBA98 0 0 00000000
0040FC70 1C000040 1 10 80000000 0 0 00000000
00448E11 1C000044 1 11 10000000 0 0 00000000
00488E12 1C000048 1 12 F0000000 0 0 00000000
02000053 1C00004C 1 13 00000001 0 0 00000000
027FFC74 1C000050 1 14 00000001 0 0 00000000
037C3C55 1C000054 1 15 00000F0F 0 0 00000000
03E00056 1C000058 1 16 FFFFF7FF 0 0 00000000
1C000037 1C00005C 1 17 1C00105C 0 0 00000000
02848C00 1C000060 1 00 00000123 0 0 00000000
00100C18 1C000064 1 18 00000005 0 0 00000000
58000878 1C000068 0 00 00000000 0 1 1C000070
5C000878 1C00006C 0 00 00000000 0 0 1C000074
63FFF043 1C000070 0 00 00000000 0 1 1C000060
64000443 1C000074 0 00 00000000 0 0 1C000078
68000443 1C000078 0 00 00000000 0 0 1C00007C
6C010043 1C00007C 0 00 00000000 0 1 1C00017C
50020000 1C000080 0 00 00000000 0 1 1C000280
500003F0 1C000084 0 00 00000000 0 1 1BC00084
54100000 1C000088 1 01 1C00008C 0 1 1C001088
4C001039 1C00008C 1 19 1C000090 0 1 1C00009C
FFFFFFFF 1C000090 0 00 00000000 1 0 00000000
00000000 1C000094 0 00 00000000 1 0 00000000
0010033A 1C000098 1 1A 1C000090 0 0 00000000

// ==== sim.f ====
+incdir+rtl
rtl/isa_pkg.sv
rtl/pipe_pkg.sv
rtl/stage_ifs.sv
rtl/insn_decode.sv
rtl/alu_execute.sv
rtl/result_writeback.sv
rtl/core_top.sv
testbench/tb_core.sv

// ==== Makefile ====
SIM      := verilator
FLAGS    := --binary --timing --timescale 1ns/100ps
TOP      := tb_core
FILELIST := sim.f

OBJDIR   := obj_dir
BIN      := $(OBJDIR)/V$(TOP)
SOURCES  := $(shell grep -E '\.s?v$$' $(FILELIST)) $(wildcard rtl/*.svh)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -o V$(TOP) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx 'TEST RESULT: PASS'

clean:
	rm -rf $(OBJDIR)
